// ==== rocc_pkg.sv ====
/*
 * RoCC side definitions shared by the bridge
 *   - Rocket address, data and register index widths
 *   - funct7 command codes and memory command and size encodings
 *   - core command, core response and memory request/response structs
 */

package rocc_pkg;

  ////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////

  // rocket physical address
  localparam int rocc_addr_width_gp = 40;
  // register file and memory data path
  localparam int rocc_data_width_gp = 64;
  // register index in the instruction
  localparam int rocc_reg_addr_width_gp = 5;
  // memory tag, the bridge always sends zero
  localparam int rocc_mem_tag_width_gp = 8;

  ////////////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////////////

  // command codes carried in funct7, other codes are ignored
  typedef enum logic [6:0] {
    core_write    = 7'd0,
    core_read     = 7'd1,
    core_seg_addr = 7'd2,
    core_reset    = 7'd3
  } rocc_funct7_e;

  typedef enum logic [4:0] {
    mem_load  = 5'd0,
    mem_store = 5'd1
  } rocc_mem_cmd_e;

  // only word accesses are issued
  typedef enum logic [2:0] {
    mem_word32 = 3'd2
  } rocc_mem_typ_e;

  ////////////////////////////////////////////////////////////////////
  // structs
  ////////////////////////////////////////////////////////////////////

  // funct7 kept as raw bits so undefined codes can still arrive
  typedef struct packed {
    logic [6:0]                        funct7;
    logic [rocc_reg_addr_width_gp-1:0] rd;
    logic [rocc_data_width_gp-1:0]     rs1_val;
    logic [rocc_data_width_gp-1:0]     rs2_val;
  } rocc_cmd_t;

  typedef struct packed {
    logic [rocc_reg_addr_width_gp-1:0] rd;
    logic [rocc_data_width_gp-1:0]     rd_data;
  } rocc_resp_t;

  typedef struct packed {
    logic [rocc_addr_width_gp-1:0]    addr;
    logic [rocc_mem_tag_width_gp-1:0] tag;
    rocc_mem_cmd_e                    cmd;
    rocc_mem_typ_e                    typ;
    logic                             phys;
    logic [rocc_data_width_gp-1:0]    data;
  } rocc_mem_req_t;

  typedef struct packed {
    rocc_mem_cmd_e                 cmd;
    logic [rocc_data_width_gp-1:0] data;
  } rocc_mem_resp_t;

endpackage

// ==== manycore_pkg.sv ====
/*
 * Manycore side definitions shared by the bridge
 *   - word, byte, coordinate and segment widths
 *   - remote address layout held in a RoCC source register
 *   - outgoing packet and incoming request structs
 */

package manycore_pkg;

  ////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////

  localparam int mc_addr_width_gp = 16;
  localparam int mc_data_width_gp = 32;
  localparam int mc_x_width_gp    = 4;
  localparam int mc_y_width_gp    = 5;

  // one byte enable per data byte
  localparam int mc_mask_width_gp = mc_data_width_gp / 8;

  // word address plus the two byte offset bits
  localparam int mc_byte_addr_width_gp = mc_addr_width_gp + 2;

  // upper rocket address bits supplied by the segment register
  localparam int mc_seg_width_gp = rocc_pkg::rocc_addr_width_gp - mc_byte_addr_width_gp;

  ////////////////////////////////////////////////////////////////////
  // remote address and packets
  ////////////////////////////////////////////////////////////////////

  // taken from the low bits of rs1
  typedef struct packed {
    logic [mc_y_width_gp-1:0]    y_cord;
    logic [mc_x_width_gp-1:0]    x_cord;
    logic [mc_addr_width_gp-1:0] word_addr;
  } mc_addr_t;

  typedef enum logic [1:0] {
    remote_load  = 2'd0,
    remote_store = 2'd1
  } mc_op_e;

  typedef struct packed {
    mc_op_e                      op;
    logic [mc_mask_width_gp-1:0] mask;
    logic [mc_addr_width_gp-1:0] addr;
    logic [mc_data_width_gp-1:0] data;
    logic [mc_x_width_gp-1:0]    x_cord;
    logic [mc_y_width_gp-1:0]    y_cord;
    logic [mc_x_width_gp-1:0]    src_x_cord;
    logic [mc_y_width_gp-1:0]    src_y_cord;
  } mc_packet_t;

  // request arriving from the mesh into this tile
  typedef struct packed {
    logic [mc_addr_width_gp-1:0] addr;
    logic [mc_data_width_gp-1:0] data;
    logic [mc_mask_width_gp-1:0] mask;
    logic                        we;
  } mc_in_req_t;

endpackage

// ==== rocc_cmd_to_manycore.sv ====
/*
 * Core command unit
 *   - funct7 decode of accepted RoCC commands
 *   - segment register and manycore reset pulse
 *   - remote store and load packets toward the mesh
 */

module rocc_cmd_to_manycore #(
  parameter int reset_cycles_p = 1
) (
  input  logic                                          rocket_clk_i,
  input  logic                                          rocket_reset_i,

  input  logic                                          core_cmd_valid_i,
  input  rocc_pkg::rocc_cmd_t                           core_cmd_i,
  output logic                                          core_cmd_ready_o,

  output logic                                          mc_out_v_o,
  output manycore_pkg::mc_packet_t                      mc_out_packet_o,
  input  logic                                          mc_out_ready_i,

  input  logic                                          read_pending_i,
  input  logic [manycore_pkg::mc_x_width_gp-1:0]        my_x_i,
  input  logic [manycore_pkg::mc_y_width_gp-1:0]        my_y_i,

  output logic [manycore_pkg::mc_seg_width_gp-1:0]      seg_addr_o,
  output logic                                          read_issue_o,
  output logic [rocc_pkg::rocc_reg_addr_width_gp-1:0]   read_rd_o,
  output logic                                          reset_manycore_o
);

  localparam int cnt_width_lp = $clog2(reset_cycles_p + 1);

  logic                        is_write;
  logic                        is_read;
  logic                        is_seg;
  logic                        is_reset;
  logic                        cmd_fire;
  manycore_pkg::mc_addr_t      dest;
  logic [cnt_width_lp-1:0]     reset_cnt_r;

  ////////////////////////////////////////////////////////////////////
  // decode and handshake
  ////////////////////////////////////////////////////////////////////

  assign is_write = (core_cmd_i.funct7 == rocc_pkg::core_write);
  assign is_read  = (core_cmd_i.funct7 == rocc_pkg::core_read);
  assign is_seg   = (core_cmd_i.funct7 == rocc_pkg::core_seg_addr);
  assign is_reset = (core_cmd_i.funct7 == rocc_pkg::core_reset);

  // a remote read blocks every command until its reply is back
  assign core_cmd_ready_o = mc_out_ready_i & ~read_pending_i;
  assign cmd_fire         = core_cmd_valid_i & core_cmd_ready_o;

  assign read_issue_o = cmd_fire & is_read;
  assign read_rd_o    = core_cmd_i.rd;

  ////////////////////////////////////////////////////////////////////
  // segment register and reset pulse
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge rocket_clk_i) begin
    if (rocket_reset_i) begin
      seg_addr_o <= '0;
    end else if (cmd_fire && is_seg) begin
      seg_addr_o <= core_cmd_i.rs1_val[rocc_pkg::rocc_addr_width_gp-1:
                                       manycore_pkg::mc_byte_addr_width_gp];
    end
  end

  // counts the remaining pulse cycles, a new reset command reloads it
  always_ff @(posedge rocket_clk_i) begin
    if (rocket_reset_i) begin
      reset_cnt_r <= '0;
    end else if (cmd_fire && is_reset) begin
      reset_cnt_r <= cnt_width_lp'(reset_cycles_p);
    end else if (reset_cnt_r != '0) begin
      reset_cnt_r <= reset_cnt_r - 1'b1;
    end
  end

  assign reset_manycore_o = (reset_cnt_r != '0);

  ////////////////////////////////////////////////////////////////////
  // outgoing packet
  ////////////////////////////////////////////////////////////////////

  assign dest = core_cmd_i.rs1_val[$bits(manycore_pkg::mc_addr_t)-1:0];

  // offered while the command itself is waiting, mc_out_ready_i stalls both
  assign mc_out_v_o = core_cmd_valid_i & (is_write | is_read) & ~read_pending_i;

  always_comb begin
    mc_out_packet_o.op         = is_write ? manycore_pkg::remote_store
                                          : manycore_pkg::remote_load;
    mc_out_packet_o.mask       = '1;
    mc_out_packet_o.addr       = dest.word_addr;
    mc_out_packet_o.data       = core_cmd_i.rs2_val[manycore_pkg::mc_data_width_gp-1:0];
    mc_out_packet_o.x_cord     = dest.x_cord;
    mc_out_packet_o.y_cord     = dest.y_cord;
    mc_out_packet_o.src_x_cord = my_x_i;
    mc_out_packet_o.src_y_cord = my_y_i;
  end

endmodule

// ==== manycore_to_rocket_mem.sv ====
/*
 * Memory path from the mesh into Rocket
 *   - word requests built from incoming manycore loads and stores
 *   - single outstanding request tracking
 *   - load data returned to the manycore
 */

module manycore_to_rocket_mem (
  input  logic                                       rocket_clk_i,
  input  logic                                       rocket_reset_i,

  input  logic                                       mc_in_v_i,
  input  manycore_pkg::mc_in_req_t                   mc_in_req_i,
  output logic                                       mc_in_yumi_o,

  input  logic [manycore_pkg::mc_seg_width_gp-1:0]   seg_addr_i,

  output logic                                       mem_req_valid_o,
  output rocc_pkg::rocc_mem_req_t                    mem_req_o,
  input  logic                                       mem_req_ready_i,

  input  logic                                       mem_resp_valid_i,
  input  rocc_pkg::rocc_mem_resp_t                   mem_resp_i,

  output logic                                       mc_returning_v_o,
  output logic [manycore_pkg::mc_data_width_gp-1:0]  mc_returning_data_o,

  output logic                                       mem_outstanding_o
);

  logic mem_outstanding_r;

  ////////////////////////////////////////////////////////////////////
  // request side
  ////////////////////////////////////////////////////////////////////

  // responses carry no usable tag, so only one request is in flight
  assign mem_req_valid_o = mc_in_v_i & ~mem_outstanding_r;
  assign mc_in_yumi_o    = mem_req_valid_o & mem_req_ready_i;

  always_comb begin
    mem_req_o.addr = {seg_addr_i, mc_in_req_i.addr, 2'b00};
    mem_req_o.tag  = '0;
    mem_req_o.cmd  = mc_in_req_i.we ? rocc_pkg::mem_store : rocc_pkg::mem_load;
    mem_req_o.typ  = rocc_pkg::mem_word32;
    mem_req_o.phys = 1'b1;
    mem_req_o.data = rocc_pkg::rocc_data_width_gp'(mc_in_req_i.data);
  end

  // both load and store responses retire the request
  always_ff @(posedge rocket_clk_i) begin
    if (rocket_reset_i) begin
      mem_outstanding_r <= 1'b0;
    end else if (mem_resp_valid_i) begin
      mem_outstanding_r <= 1'b0;
    end else if (mc_in_yumi_o) begin
      mem_outstanding_r <= 1'b1;
    end
  end

  assign mem_outstanding_o = mem_outstanding_r;

  ////////////////////////////////////////////////////////////////////
  // response side
  ////////////////////////////////////////////////////////////////////

  // store acks are swallowed, only loads send data back
  assign mc_returning_v_o    = mem_resp_valid_i & (mem_resp_i.cmd == rocc_pkg::mem_load);
  assign mc_returning_data_o = mem_resp_i.data[manycore_pkg::mc_data_width_gp-1:0];

endmodule

// ==== rocc_resp_unit.sv ====
/*
 * Core response unit
 *   - destination register of the in-flight remote read
 *   - core response on the read reply
 *   - accelerator busy flag
 */

module rocc_resp_unit (
  input  logic                                         rocket_clk_i,
  input  logic                                         rocket_reset_i,

  input  logic                                         read_issue_i,
  input  logic [rocc_pkg::rocc_reg_addr_width_gp-1:0]  read_rd_i,
  output logic                                         read_pending_o,

  input  logic                                         mc_returned_v_i,
  input  logic [manycore_pkg::mc_data_width_gp-1:0]    mc_returned_data_i,

  output logic                                         core_resp_valid_o,
  output rocc_pkg::rocc_resp_t                         core_resp_o,

  input  logic                                         mem_outstanding_i,
  output logic                                         acc_busy_o
);

  logic [rocc_pkg::rocc_reg_addr_width_gp-1:0] read_rd_r;
  logic                                        read_pending_r;

  always_ff @(posedge rocket_clk_i) begin
    if (read_issue_i) begin
      read_rd_r <= read_rd_i;
    end
  end

  // the reply wins, a new read cannot be issued while one is pending
  always_ff @(posedge rocket_clk_i) begin
    if (rocket_reset_i) begin
      read_pending_r <= 1'b0;
    end else if (mc_returned_v_i) begin
      read_pending_r <= 1'b0;
    end else if (read_issue_i) begin
      read_pending_r <= 1'b1;
    end
  end

  assign read_pending_o = read_pending_r;

  // the core is always ready, so the reply goes straight through
  assign core_resp_valid_o   = mc_returned_v_i;
  assign core_resp_o.rd      = read_rd_r;
  assign core_resp_o.rd_data = rocc_pkg::rocc_data_width_gp'(mc_returned_data_i);

  assign acc_busy_o = read_pending_r | mem_outstanding_i;

endmodule

// ==== manycore_rocc_bridge.sv ====
/*
 * Bridge between a Rocket RoCC port and one manycore tile
 *   - command unit, memory path and response unit
 *   - wiring between them, no logic of its own
 */

module manycore_rocc_bridge #(
  parameter int reset_cycles_p = 1
) (
  input  logic                                         rocket_clk_i,
  input  logic                                         rocket_reset_i,

  // core command and response
  input  logic                                         core_cmd_valid_i,
  input  rocc_pkg::rocc_cmd_t                          core_cmd_i,
  output logic                                         core_cmd_ready_o,
  output logic                                         core_resp_valid_o,
  output rocc_pkg::rocc_resp_t                         core_resp_o,

  // manycore outgoing packets and read replies
  output logic                                         mc_out_v_o,
  output manycore_pkg::mc_packet_t                     mc_out_packet_o,
  input  logic                                         mc_out_ready_i,
  input  logic                                         mc_returned_v_i,
  input  logic [manycore_pkg::mc_data_width_gp-1:0]    mc_returned_data_i,

  // manycore incoming requests and load data
  input  logic                                         mc_in_v_i,
  input  manycore_pkg::mc_in_req_t                     mc_in_req_i,
  output logic                                         mc_in_yumi_o,
  output logic                                         mc_returning_v_o,
  output logic [manycore_pkg::mc_data_width_gp-1:0]    mc_returning_data_o,

  // rocket memory
  output logic                                         mem_req_valid_o,
  output rocc_pkg::rocc_mem_req_t                      mem_req_o,
  input  logic                                         mem_req_ready_i,
  input  logic                                         mem_resp_valid_i,
  input  rocc_pkg::rocc_mem_resp_t                     mem_resp_i,

  // status
  input  logic [manycore_pkg::mc_x_width_gp-1:0]       my_x_i,
  input  logic [manycore_pkg::mc_y_width_gp-1:0]       my_y_i,
  output logic                                         reset_manycore_o,
  output logic                                         acc_busy_o
);

  logic [manycore_pkg::mc_seg_width_gp-1:0]     seg_addr;
  logic                                         read_issue;
  logic [rocc_pkg::rocc_reg_addr_width_gp-1:0]  read_rd;
  logic                                         read_pending;
  logic                                         mem_outstanding;

  rocc_cmd_to_manycore #(
    .reset_cycles_p (reset_cycles_p)
  ) cmd_unit (
    .rocket_clk_i     (rocket_clk_i),
    .rocket_reset_i   (rocket_reset_i),
    .core_cmd_valid_i (core_cmd_valid_i),
    .core_cmd_i       (core_cmd_i),
    .core_cmd_ready_o (core_cmd_ready_o),
    .mc_out_v_o       (mc_out_v_o),
    .mc_out_packet_o  (mc_out_packet_o),
    .mc_out_ready_i   (mc_out_ready_i),
    .read_pending_i   (read_pending),
    .my_x_i           (my_x_i),
    .my_y_i           (my_y_i),
    .seg_addr_o       (seg_addr),
    .read_issue_o     (read_issue),
    .read_rd_o        (read_rd),
    .reset_manycore_o (reset_manycore_o)
  );

  manycore_to_rocket_mem mem_unit (
    .rocket_clk_i        (rocket_clk_i),
    .rocket_reset_i      (rocket_reset_i),
    .mc_in_v_i           (mc_in_v_i),
    .mc_in_req_i         (mc_in_req_i),
    .mc_in_yumi_o        (mc_in_yumi_o),
    .seg_addr_i          (seg_addr),
    .mem_req_valid_o     (mem_req_valid_o),
    .mem_req_o           (mem_req_o),
    .mem_req_ready_i     (mem_req_ready_i),
    .mem_resp_valid_i    (mem_resp_valid_i),
    .mem_resp_i          (mem_resp_i),
    .mc_returning_v_o    (mc_returning_v_o),
    .mc_returning_data_o (mc_returning_data_o),
    .mem_outstanding_o   (mem_outstanding)
  );

  rocc_resp_unit resp_unit (
    .rocket_clk_i       (rocket_clk_i),
    .rocket_reset_i     (rocket_reset_i),
    .read_issue_i       (read_issue),
    .read_rd_i          (read_rd),
    .read_pending_o     (read_pending),
    .mc_returned_v_i    (mc_returned_v_i),
    .mc_returned_data_i (mc_returned_data_i),
    .core_resp_valid_o  (core_resp_valid_o),
    .core_resp_o        (core_resp_o),
    .mem_outstanding_i  (mem_outstanding),
    .acc_busy_o         (acc_busy_o)
  );

endmodule

// ==== bridge_sva.sv ====
/*
 * Protocol assertions bound into the bridge top level
 *   - yumi only with a memory handshake
 *   - one outstanding memory request
 *   - core responses only for a pending read
 */

module bridge_sva (
  input logic rocket_clk_i,
  input logic rocket_reset_i,
  input logic yumi_i,
  input logic mem_req_valid_i,
  input logic mem_req_ready_i,
  input logic mem_resp_valid_i,
  input logic core_resp_valid_i,
  input logic read_pending_i
);
  timeunit 1ns;
  timeprecision 100ps;

  logic in_flight_r;

  // request handed to rocket and not yet answered
  always_ff @(posedge rocket_clk_i) begin
    if (rocket_reset_i) begin
      in_flight_r <= 1'b0;
    end else if (mem_resp_valid_i) begin
      in_flight_r <= 1'b0;
    end else if (mem_req_valid_i && mem_req_ready_i) begin
      in_flight_r <= 1'b1;
    end
  end

  yumi_with_handshake: assert property (
    @(posedge rocket_clk_i) disable iff (rocket_reset_i)
    yumi_i |-> (mem_req_valid_i && mem_req_ready_i && !in_flight_r)
  ) else $error("incoming request consumed without a new memory handshake");

  single_outstanding: assert property (
    @(posedge rocket_clk_i) disable iff (rocket_reset_i)
    in_flight_r |-> !mem_req_valid_i
  ) else $error("memory request issued while another is outstanding");

  resp_needs_read: assert property (
    @(posedge rocket_clk_i) disable iff (rocket_reset_i)
    core_resp_valid_i |-> read_pending_i
  ) else $error("core response without a pending remote read");

endmodule

bind manycore_rocc_bridge bridge_sva bridge_checks (
  .rocket_clk_i      (rocket_clk_i),
  .rocket_reset_i    (rocket_reset_i),
  .yumi_i            (mc_in_yumi_o),
  .mem_req_valid_i   (mem_req_valid_o),
  .mem_req_ready_i   (mem_req_ready_i),
  .mem_resp_valid_i  (mem_resp_valid_i),
  .core_resp_valid_i (core_resp_valid_o),
  .read_pending_i    (read_pending)
);

// ==== tb_manycore_rocc_bridge.sv ====
/*
 * Testbench for the manycore RoCC bridge
 *   - clock, reset and three random stimulus streams
 *   - cycle model with expected packet, response, request and word queues
 *   - compare tasks, watchdog and closing summary
 */

module tb_manycore_rocc_bridge;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int n_cmds_lp         = 200;
  localparam int n_ins_lp          = 200;
  localparam int clk_period_lp     = 8;
  localparam int reset_cycles_lp   = 3;
  localparam int timeout_cycles_lp = (n_cmds_lp + n_ins_lp) * 40;

  logic                                     rocket_clk_i;
  logic                                     rocket_reset_i;
  logic                                     core_cmd_valid_i;
  rocc_pkg::rocc_cmd_t                      core_cmd_i;
  logic                                     core_cmd_ready_o;
  logic                                     core_resp_valid_o;
  rocc_pkg::rocc_resp_t                     core_resp_o;
  logic                                     mc_out_v_o;
  manycore_pkg::mc_packet_t                 mc_out_packet_o;
  logic                                     mc_out_ready_i;
  logic                                     mc_returned_v_i;
  logic [manycore_pkg::mc_data_width_gp-1:0] mc_returned_data_i;
  logic                                     mc_in_v_i;
  manycore_pkg::mc_in_req_t                 mc_in_req_i;
  logic                                     mc_in_yumi_o;
  logic                                     mc_returning_v_o;
  logic [manycore_pkg::mc_data_width_gp-1:0] mc_returning_data_o;
  logic                                     mem_req_valid_o;
  rocc_pkg::rocc_mem_req_t                  mem_req_o;
  logic                                     mem_req_ready_i;
  logic                                     mem_resp_valid_i;
  rocc_pkg::rocc_mem_resp_t                 mem_resp_i;
  logic [manycore_pkg::mc_x_width_gp-1:0]   my_x_i;
  logic [manycore_pkg::mc_y_width_gp-1:0]   my_y_i;
  logic                                     reset_manycore_o;
  logic                                     acc_busy_o;

  // model state, updated once per cycle at the falling edge
  manycore_pkg::mc_packet_t                  exp_packets[$];
  rocc_pkg::rocc_mem_req_t                   exp_mem_reqs[$];
  rocc_pkg::rocc_resp_t                      exp_resps[$];
  logic [manycore_pkg::mc_data_width_gp-1:0] exp_words[$];
  logic [rocc_pkg::rocc_reg_addr_width_gp-1:0] read_rd_m;
  logic [manycore_pkg::mc_seg_width_gp-1:0]    seg_m = '0;
  logic running = 1'b0;
  logic read_pending_m = 1'b0;
  logic mem_out_m = 1'b0;
  logic mem_we_m = 1'b0;
  logic cmd_taken = 1'b0;
  logic in_taken = 1'b0;
  int   reset_left_m = 0;
  int   cmds_sent = 0;
  int   ins_sent = 0;
  int   packet_errs = 0;
  int   mem_errs = 0;
  int   resp_errs = 0;
  int   word_errs = 0;
  int   flag_errs = 0;
  int   other_errs = 0;

  manycore_rocc_bridge #(.reset_cycles_p(reset_cycles_lp)) dut (.*);

  ////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////

  task automatic check_packet(input string name, input manycore_pkg::mc_packet_t exp,
                              input manycore_pkg::mc_packet_t act);
    if (exp !== act) begin
      packet_errs++;
      $display("Fail %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_mem_req(input string name, input rocc_pkg::rocc_mem_req_t exp,
                               input rocc_pkg::rocc_mem_req_t act);
    if (exp !== act) begin
      mem_errs++;
      $display("Fail %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input rocc_pkg::rocc_resp_t exp,
                            input rocc_pkg::rocc_resp_t act);
    if (exp !== act) begin
      resp_errs++;
      $display("Fail %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_word(input string name,
                            input logic [manycore_pkg::mc_data_width_gp-1:0] exp,
                            input logic [manycore_pkg::mc_data_width_gp-1:0] act);
    if (exp !== act) begin
      word_errs++;
      $display("Fail %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      flag_errs++;
      $display("Fail %s expected %b actual %b", name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // clock, stimulus streams and watchdog
  ////////////////////////////////////////////////////////////////////

  initial begin : clock_gen
    rocket_clk_i = 1'b0;
    forever #(clk_period_lp / 2) rocket_clk_i = ~rocket_clk_i;
  end

  // core commands held until accepted
  initial begin : cmd_stream
    wait (running);
    forever begin
      @(posedge rocket_clk_i);
      #1;
      if (cmd_taken || !core_cmd_valid_i) begin
        cmd_taken        = 1'b0;
        core_cmd_valid_i = 1'b0;
        if (cmds_sent < n_cmds_lp && $urandom_range(0, 2) != 0) begin
          core_cmd_i.funct7  = 7'($urandom_range(0, 4));
          core_cmd_i.rd      = 5'($urandom);
          core_cmd_i.rs1_val = {$urandom, $urandom};
          core_cmd_i.rs2_val = {$urandom, $urandom};
          core_cmd_valid_i   = 1'b1;
          cmds_sent++;
        end
      end
    end
  end

  // incoming manycore requests held until yumi
  initial begin : in_stream
    wait (running);
    forever begin
      @(posedge rocket_clk_i);
      #1;
      if (in_taken || !mc_in_v_i) begin
        in_taken  = 1'b0;
        mc_in_v_i = 1'b0;
        if (ins_sent < n_ins_lp && $urandom_range(0, 1) == 0) begin
          mc_in_req_i.addr = 16'($urandom);
          mc_in_req_i.data = $urandom;
          mc_in_req_i.mask = '1;
          mc_in_req_i.we   = 1'($urandom);
          mc_in_v_i        = 1'b1;
          ins_sent++;
        end
      end
    end
  end

  // ready stalls and geometric reply delays
  initial begin : delay_stream
    wait (running);
    forever begin
      @(posedge rocket_clk_i);
      #1;
      mc_out_ready_i     = ($urandom_range(0, 3) != 0);
      mem_req_ready_i    = ($urandom_range(0, 2) != 0);
      mc_returned_v_i    = read_pending_m && ($urandom_range(0, 3) == 0);
      mc_returned_data_i = $urandom;
      mem_resp_valid_i   = mem_out_m && ($urandom_range(0, 2) == 0);
      mem_resp_i.cmd     = mem_we_m ? rocc_pkg::mem_store : rocc_pkg::mem_load;
      mem_resp_i.data    = {$urandom, $urandom};
    end
  end

  initial begin : watchdog
    #(timeout_cycles_lp * clk_period_lp);
    $display("timeout, the run did not finish within %0d cycles", timeout_cycles_lp);
    $display("Regression failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////
  // reference model and checks
  ////////////////////////////////////////////////////////////////////

  always @(negedge rocket_clk_i) begin : model_check
    logic cmd_fire;
    logic is_wr;
    logic is_rd;
    logic exp_mem_v;
    logic mem_fire;
    manycore_pkg::mc_packet_t pkt;
    rocc_pkg::rocc_mem_req_t  req;
    rocc_pkg::rocc_resp_t     resp;
    if (running) begin
      is_wr    = (core_cmd_i.funct7 == 7'd0);
      is_rd    = (core_cmd_i.funct7 == 7'd1);
      cmd_fire = core_cmd_valid_i && mc_out_ready_i && !read_pending_m;
      check_flag("cmd_ready", mc_out_ready_i && !read_pending_m, core_cmd_ready_o);
      check_flag("out_valid", core_cmd_valid_i && (is_wr || is_rd) && !read_pending_m,
                 mc_out_v_o);
      if (cmd_fire && (is_wr || is_rd)) begin
        pkt.op         = is_wr ? manycore_pkg::remote_store : manycore_pkg::remote_load;
        pkt.mask       = '1;
        pkt.addr       = core_cmd_i.rs1_val[15:0];
        pkt.data       = core_cmd_i.rs2_val[31:0];
        pkt.x_cord     = core_cmd_i.rs1_val[19:16];
        pkt.y_cord     = core_cmd_i.rs1_val[24:20];
        pkt.src_x_cord = my_x_i;
        pkt.src_y_cord = my_y_i;
        exp_packets.push_back(pkt);
      end
      if (mc_out_v_o && mc_out_ready_i) begin
        if (exp_packets.size() == 0) begin
          other_errs++;
          $display("a packet was sent with no accepted write or read");
        end else begin
          check_packet("remote_packet", exp_packets.pop_front(), mc_out_packet_o);
        end
      end

      // read reply goes straight to the core
      check_flag("resp_valid", mc_returned_v_i, core_resp_valid_o);
      if (mc_returned_v_i) begin
        resp.rd      = read_rd_m;
        resp.rd_data = {32'b0, mc_returned_data_i};
        exp_resps.push_back(resp);
      end
      if (core_resp_valid_o) begin
        if (exp_resps.size() == 0) begin
          other_errs++;
          $display("a core response appeared with no read reply");
        end else begin
          check_resp("core_resp", exp_resps.pop_front(), core_resp_o);
        end
      end

      // memory path, one request in flight
      exp_mem_v = mc_in_v_i && !mem_out_m;
      mem_fire  = exp_mem_v && mem_req_ready_i;
      check_flag("mem_req_valid", exp_mem_v, mem_req_valid_o);
      check_flag("in_yumi", mem_fire, mc_in_yumi_o);
      if (mem_fire) begin
        req.addr = {seg_m, mc_in_req_i.addr, 2'b00};
        req.tag  = '0;
        req.cmd  = mc_in_req_i.we ? rocc_pkg::mem_store : rocc_pkg::mem_load;
        req.typ  = rocc_pkg::mem_word32;
        req.phys = 1'b1;
        req.data = {32'b0, mc_in_req_i.data};
        exp_mem_reqs.push_back(req);
      end
      if (mem_req_valid_o && mem_req_ready_i) begin
        if (exp_mem_reqs.size() == 0) begin
          other_errs++;
          $display("a memory request was issued with no incoming request");
        end else begin
          check_mem_req("mem_req", exp_mem_reqs.pop_front(), mem_req_o);
        end
      end
      check_flag("returning_v", mem_resp_valid_i && !mem_we_m, mc_returning_v_o);
      if (mem_resp_valid_i && !mem_we_m) begin
        exp_words.push_back(mem_resp_i.data[31:0]);
      end
      if (mc_returning_v_o) begin
        if (exp_words.size() == 0) begin
          other_errs++;
          $display("load data was returned with no load response");
        end else begin
          check_word("returning_data", exp_words.pop_front(), mc_returning_data_o);
        end
      end

      check_flag("reset_manycore", reset_left_m != 0, reset_manycore_o);
      check_flag("acc_busy", read_pending_m || mem_out_m, acc_busy_o);

      // state for the next cycle
      if (cmd_fire) begin
        cmd_taken = 1'b1;
        if (core_cmd_i.funct7 == 7'd2) begin
          seg_m = core_cmd_i.rs1_val[39:18];
        end
      end
      if (cmd_fire && core_cmd_i.funct7 == 7'd3) begin
        reset_left_m = reset_cycles_lp;
      end else if (reset_left_m != 0) begin
        reset_left_m--;
      end
      if (mc_returned_v_i) begin
        read_pending_m = 1'b0;
      end else if (cmd_fire && is_rd) begin
        read_pending_m = 1'b1;
        read_rd_m      = core_cmd_i.rd;
      end
      if (mem_resp_valid_i) begin
        mem_out_m = 1'b0;
      end else if (mem_fire) begin
        mem_out_m = 1'b1;
        mem_we_m  = mc_in_req_i.we;
      end
      if (mem_fire) begin
        in_taken = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////

  initial begin : main_seq
    int seed_val;
    int total_errs;
    seed_val           = $urandom(55690);
    rocket_reset_i     = 1'b1;
    core_cmd_valid_i   = 1'b0;
    core_cmd_i         = '0;
    mc_out_ready_i     = 1'b0;
    mc_returned_v_i    = 1'b0;
    mc_returned_data_i = '0;
    mc_in_v_i          = 1'b0;
    mc_in_req_i        = '0;
    mem_req_ready_i    = 1'b0;
    mem_resp_valid_i   = 1'b0;
    mem_resp_i         = '0;
    my_x_i             = 4'($urandom);
    my_y_i             = 5'($urandom);
    repeat (8) @(posedge rocket_clk_i);
    #1;
    rocket_reset_i = 1'b0;
    running        = 1'b1;

    wait (cmds_sent == n_cmds_lp && ins_sent == n_ins_lp);
    wait (!core_cmd_valid_i && !mc_in_v_i && !read_pending_m && !mem_out_m &&
          reset_left_m == 0);
    repeat (4) @(posedge rocket_clk_i);

    if (exp_packets.size() + exp_mem_reqs.size() + exp_resps.size() +
        exp_words.size() != 0) begin
      other_errs++;
      $display("some expected outputs never appeared at the DUT ports");
    end
    total_errs = packet_errs + mem_errs + resp_errs + word_errs + flag_errs + other_errs;
    $display("errors: packet %0d mem_req %0d resp %0d word %0d flag %0d other %0d",
             packet_errs, mem_errs, resp_errs, word_errs, flag_errs, other_errs);
    if (total_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
rocc_pkg.sv
manycore_pkg.sv
rocc_cmd_to_manycore.sv
manycore_to_rocket_mem.sv
rocc_resp_unit.sv
manycore_rocc_bridge.sv
bridge_sva.sv
tb_manycore_rocc_bridge.sv

// ==== Bender.yml ====
package:
  name: manycore_rocc_bridge

sources:
  # packages first, rocc_pkg is used by manycore_pkg
  - rocc_pkg.sv
  - manycore_pkg.sv
  # design units and top level
  - rocc_cmd_to_manycore.sv
  - manycore_to_rocket_mem.sv
  - rocc_resp_unit.sv
  - manycore_rocc_bridge.sv
  # testbench and bound assertions
  - target: test
    files:
      - bridge_sva.sv
      - tb_manycore_rocc_bridge.sv
